// ==== rtl/keccak_pkg.sv ====
`default_nettype none

package keccak_pkg;

  localparam int lane_w     = 64;
  localparam int n_rounds   = 24;
  localparam int rate_w     = 1088;
  localparam int capacity_w = 512;

  // lane (x,y) at position 5y+x, lane (0,0) in the top 64 bits
  typedef logic [25*lane_w-1:0] state_t;
  typedef logic [lane_w-1:0] lane_t;
  typedef logic [4:0] round_idx_t;

  typedef enum logic {
    idle,
    run
  } perm_state_e;

  ////////////////////////////////////////////////////////////
  // iota constants, one per round
  ////////////////////////////////////////////////////////////
  localparam lane_t round_consts [n_rounds] = '{
    64'h0000_0000_0000_0001,
    64'h0000_0000_0000_8082,
    64'h8000_0000_0000_808a,
    64'h8000_0000_8000_8000,
    64'h0000_0000_0000_808b,
    64'h0000_0000_8000_0001,
    64'h8000_0000_8000_8081,
    64'h8000_0000_0000_8009,
    64'h0000_0000_0000_008a,
    64'h0000_0000_0000_0088,
    64'h0000_0000_8000_8009,
    64'h0000_0000_8000_000a,
    64'h0000_0000_8000_808b,
    64'h8000_0000_0000_008b,
    64'h8000_0000_0000_8089,
    64'h8000_0000_0000_8003,
    64'h8000_0000_0000_8002,
    64'h8000_0000_0000_0080,
    64'h0000_0000_0000_800a,
    64'h8000_0000_8000_000a,
    64'h8000_0000_8000_8081,
    64'h8000_0000_0000_8080,
    64'h0000_0000_8000_0001,
    64'h8000_0000_8000_8008
  };

  // rho left-rotation amounts, indexed by 5y+x
  localparam int unsigned rho_offsets [25] = '{
     0,  1, 62, 28, 27,
    36, 44,  6, 55, 20,
     3, 10, 43, 25, 39,
    41, 45, 15, 21,  8,
    18,  2, 61, 56, 14
  };

  // swaps byte order inside one lane
  function automatic lane_t lane_byte_swap(lane_t v);
    lane_t r;
    for (int b = 0; b < lane_w / 8; b++)
    begin
      r[b*8 +: 8] = v[(lane_w/8 - 1 - b)*8 +: 8];
    end
    return r;
  endfunction

endpackage

`default_nettype wire

// ==== rtl/miner_pkg.sv ====
`default_nettype none

package miner_pkg;

  localparam int header_w     = 608;
  localparam int nonce_w      = 32;
  localparam int target_w     = 64;
  localparam int digest_w     = 256;
  localparam int digest_lanes = 4;

  typedef logic [header_w-1:0] header_t;
  typedef logic [nonce_w-1:0]  nonce_t;
  typedef logic [target_w-1:0] target_t;
  typedef logic [digest_w-1:0] digest_t;

  // 640-bit message, header in the upper bits
  typedef struct packed {
    header_t header;
    nonce_t  nonce;
  } msg_t;

  // keccak padding, first byte after message and last rate byte
  localparam logic [7:0] pad_first_byte = 8'h01;
  localparam logic [7:0] pad_last_byte  = 8'h80;

endpackage

`default_nettype wire

// ==== rtl/keccak_pad.sv ====
`default_nettype none

module keccak_pad
  import keccak_pkg::*, miner_pkg::*;
(
  input  msg_t   msg,
  output state_t state
);

  logic [rate_w-1:0] rate_block;
  logic [rate_w-1:0] rate_lanes;

  ////////////////////////////////////////////////////////////
  // message, 0x01, zero fill, 0x80 in the last rate byte
  ////////////////////////////////////////////////////////////
  assign rate_block = {
    msg,
    pad_first_byte,
    {(rate_w - $bits(msg_t) - 16){1'b0}},
    pad_last_byte
  };

  // byte stream to lane order, one 64-bit word at a time
  always_comb
  begin
    for (int w = 0; w < rate_w / lane_w; w++)
    begin
      rate_lanes[w*lane_w +: lane_w] = lane_byte_swap(rate_block[w*lane_w +: lane_w]);
    end
  end

  // capacity part starts as zero
  assign state = {rate_lanes, {capacity_w{1'b0}}};

endmodule

`default_nettype wire

// ==== rtl/keccak_round.sv ====
`default_nettype none

module keccak_round
  import keccak_pkg::*;
(
  input  state_t     state_in,
  input  round_idx_t round,
  output state_t     state_out
);

  // lane arrays indexed [x][y]
  lane_t a   [5][5];
  lane_t b   [5][5];
  lane_t chi [5][5];
  lane_t par [5];
  lane_t mix [5];

  function automatic lane_t rotl(lane_t v, int unsigned n);
    return (v << n) | (v >> (lane_w - n));
  endfunction

  always_comb
  begin
    // unpack, lane (0,0) in the top bits
    for (int y = 0; y < 5; y++)
    begin
      for (int x = 0; x < 5; x++)
      begin
        a[x][y] = state_in[(24 - (5*y + x))*lane_w +: lane_w];
      end
    end

    ////////////////////////////////////////////////////////////
    // theta
    ////////////////////////////////////////////////////////////
    for (int x = 0; x < 5; x++)
    begin
      par[x] = a[x][0] ^ a[x][1] ^ a[x][2] ^ a[x][3] ^ a[x][4];
    end
    for (int x = 0; x < 5; x++)
    begin
      mix[x] = par[(x + 4) % 5] ^ rotl(par[(x + 1) % 5], 1);
    end

    ////////////////////////////////////////////////////////////
    // rho and pi together
    ////////////////////////////////////////////////////////////
    // lane (x,y) moves to (y, 2x+3y)
    for (int y = 0; y < 5; y++)
    begin
      for (int x = 0; x < 5; x++)
      begin
        b[y][(2*x + 3*y) % 5] = rotl(a[x][y] ^ mix[x], rho_offsets[5*y + x]);
      end
    end

    ////////////////////////////////////////////////////////////
    // chi, row by row
    ////////////////////////////////////////////////////////////
    for (int y = 0; y < 5; y++)
    begin
      for (int x = 0; x < 5; x++)
      begin
        chi[x][y] = b[x][y] ^ (~b[(x + 1) % 5][y] & b[(x + 2) % 5][y]);
      end
    end

    // iota only touches lane (0,0)
    chi[0][0] = chi[0][0] ^ round_consts[round];

    for (int y = 0; y < 5; y++)
    begin
      for (int x = 0; x < 5; x++)
      begin
        state_out[(24 - (5*y + x))*lane_w +: lane_w] = chi[x][y];
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/keccak_permutation.sv ====
`default_nettype none

module keccak_permutation
  import keccak_pkg::*;
(
  input  logic   clk,
  input  logic   arst_n,
  input  logic   start,
  input  state_t init_state,
  output logic   busy,
  output logic   perm_done,
  output state_t perm_state
);

  perm_state_e fsm_q;
  round_idx_t  round_q;
  state_t      state_q;
  state_t      round_out;
  logic        last_round;

  keccak_round round0 (
    .state_in  (state_q),
    .round     (round_q),
    .state_out (round_out)
  );

  assign last_round = (round_q == round_idx_t'(n_rounds - 1));

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      fsm_q     <= idle;
      round_q   <= '0;
      perm_done <= 1'b0;
    end
    else
    begin
      perm_done <= 1'b0;
      case (fsm_q)
        idle:
        begin
          if (start)
          begin
            fsm_q   <= run;
            round_q <= '0;
          end
        end
        run:
        begin
          if (last_round)
          begin
            // final round lands this edge
            fsm_q     <= idle;
            round_q   <= '0;
            perm_done <= 1'b1;
          end
          else
            round_q <= round_q + 1'b1;
        end
      endcase
    end
  end

  // state register, loaded on start then one round per clock
  always_ff @(posedge clk)
  begin
    if (fsm_q == idle && start)
      state_q <= init_state;
    else if (fsm_q == run)
      state_q <= round_out;
  end

  assign busy       = (fsm_q == run);
  assign perm_state = state_q;

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////
  round_in_range: assert property (
    @(posedge clk) disable iff (!arst_n)
    round_q <= round_idx_t'(n_rounds - 1)
  );

  // at most one run finishes per start
  done_single_pulse: assert property (
    @(posedge clk) disable iff (!arst_n)
    perm_done |=> !perm_done
  );

endmodule

`default_nettype wire

// ==== rtl/hash_target_check.sv ====
`default_nettype none

module hash_target_check
  import keccak_pkg::*, miner_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  logic    perm_done,
  input  state_t  perm_state,
  input  target_t target,
  output logic    done,
  output digest_t digest,
  output logic    match
);

  digest_t digest_next;

  // lanes 0 to 3 with lane 0 as the top word
  always_comb
  begin
    for (int i = 0; i < digest_lanes; i++)
    begin
      digest_next[(digest_lanes - 1 - i)*lane_w +: lane_w] =
        lane_byte_swap(perm_state[(24 - i)*lane_w +: lane_w]);
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      done   <= 1'b0;
      digest <= '0;
      match  <= 1'b0;
    end
    else
    begin
      done <= perm_done;
      if (perm_done)
      begin
        digest <= digest_next;
        match  <= (digest_next[target_w-1:0] <= target);
      end
    end
  end

  // done echoes one perm_done pulse and never lasts two cycles
  done_after_perm: assert property (
    @(posedge clk) disable iff (!arst_n)
    done |-> $past(perm_done) && !$past(done)
  );

endmodule

`default_nettype wire

// ==== rtl/keccak_miner_core.sv ====
`default_nettype none

module keccak_miner_core
  import keccak_pkg::*, miner_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  logic    start,
  input  header_t header,
  input  nonce_t  nonce,
  input  target_t target,
  output logic    busy,
  output logic    done,
  output logic    match,
  output digest_t digest
);

  msg_t   msg;
  state_t init_state;
  state_t perm_state;
  logic   perm_done;

  assign msg.header = header;
  assign msg.nonce  = nonce;

  keccak_pad pad0 (
    .msg   (msg),
    .state (init_state)
  );

  keccak_permutation perm0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .start      (start),
    .init_state (init_state),
    .busy       (busy),
    .perm_done  (perm_done),
    .perm_state (perm_state)
  );

  hash_target_check check0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .perm_done  (perm_done),
    .perm_state (perm_state),
    .target     (target),
    .done       (done),
    .digest     (digest),
    .match      (match)
  );

endmodule

`default_nettype wire

// ==== bench/keccak_ref.svh ====
`ifndef KECCAK_REF_SVH
`define KECCAK_REF_SVH

// lane (x,y) kept at index x+5y, bytes little endian as in the sponge spec
typedef logic [24:0][63:0] lanes_t;
// one rate block, element i is byte i of the stream
typedef logic [135:0][7:0] block_t;

function automatic logic [63:0] rotate_left(logic [63:0] v, int n);
  return (v << n) | (v >> (64 - n));
endfunction

function automatic lanes_t keccak_f1600(lanes_t s);
  lanes_t      b;
  logic [63:0] c [5];
  logic [63:0] d;
  logic [63:0] rc;
  logic [7:0]  lfsr;
  int          rot [25];
  int          x;
  int          y;
  int          nx;
  // rho offsets are triangular numbers along the (x,y) walk
  rot[0] = 0;
  x = 1;
  y = 0;
  for (int t = 0; t < 24; t++)
  begin
    rot[x + 5*y] = ((t + 1) * (t + 2) / 2) % 64;
    nx = y;
    y = (2*x + 3*y) % 5;
    x = nx;
  end
  lfsr = 8'h01;
  for (int r = 0; r < 24; r++)
  begin
    // theta
    for (int i = 0; i < 5; i++)
    begin
      c[i] = s[i] ^ s[i + 5] ^ s[i + 10] ^ s[i + 15] ^ s[i + 20];
    end
    for (int i = 0; i < 5; i++)
    begin
      d = c[(i + 4) % 5] ^ rotate_left(c[(i + 1) % 5], 1);
      for (int j = 0; j < 5; j++)
      begin
        s[i + 5*j] = s[i + 5*j] ^ d;
      end
    end
    // rho then pi, (i,j) lands on (j, 2i+3j)
    for (int i = 0; i < 5; i++)
    begin
      for (int j = 0; j < 5; j++)
      begin
        b[j + 5*((2*i + 3*j) % 5)] = rotate_left(s[i + 5*j], rot[i + 5*j]);
      end
    end
    // chi
    for (int i = 0; i < 5; i++)
    begin
      for (int j = 0; j < 5; j++)
      begin
        s[i + 5*j] = b[i + 5*j] ^ (~b[(i + 1) % 5 + 5*j] & b[(i + 2) % 5 + 5*j]);
      end
    end
    // iota bits sit at 2^k-1, drawn from the x^8+x^6+x^5+x^4+1 LFSR
    rc = '0;
    for (int k = 0; k < 7; k++)
    begin
      rc[(1 << k) - 1] = lfsr[0];
      lfsr = lfsr[7] ? ((lfsr << 1) ^ 8'h71) : (lfsr << 1);
    end
    s[0] = s[0] ^ rc;
  end
  return s;
endfunction

// byte 8i+k of the block goes to byte k of lane i, capacity stays zero
function automatic lanes_t absorb_block(block_t blk);
  lanes_t s;
  s = '0;
  for (int i = 0; i < 136; i++)
  begin
    s[i / 8][(i % 8)*8 +: 8] = blk[i];
  end
  return s;
endfunction

// first 32 output bytes, byte 0 in the top bits
function automatic digest_t squeeze_digest(lanes_t s);
  digest_t d;
  for (int i = 0; i < 32; i++)
  begin
    d[(31 - i)*8 +: 8] = s[i / 8][(i % 8)*8 +: 8];
  end
  return d;
endfunction

function automatic block_t padded_block(header_t h, nonce_t n);
  block_t       blk;
  logic [639:0] msg;
  msg = {h, n};
  blk = '0;
  for (int i = 0; i < 80; i++)
  begin
    blk[i] = msg[(79 - i)*8 +: 8];
  end
  blk[80]  = 8'h01;
  blk[135] = blk[135] | 8'h80;
  return blk;
endfunction

function automatic digest_t expected_digest(header_t h, nonce_t n);
  return squeeze_digest(keccak_f1600(absorb_block(padded_block(h, n))));
endfunction

function automatic logic expected_match(digest_t d, target_t t);
  return d[63:0] <= t;
endfunction

`endif

// ==== bench/tb_keccak_miner.sv ====
`default_nettype none

module tb_keccak_miner
  import keccak_pkg::*, miner_pkg::*;
();

  localparam int unsigned seed = 78610;
  localparam int n_random       = 30;
  localparam int timeout_cycles = 2000;
  localparam int latency        = n_rounds + 1;

  logic    clk;
  logic    arst_n;
  logic    start;
  header_t header;
  nonce_t  nonce;
  target_t target;
  logic    busy;
  logic    done;
  logic    match;
  digest_t digest;

  int          cycle = 0;
  header_t     h;
  nonce_t      n;
  digest_t     d;
  digest_t     exp_digest;

  // runs accepted by the DUT in start order
  string   name_q [$];
  header_t header_q [$];
  nonce_t  nonce_q [$];
  target_t target_q [$];
  int      start_edge_q [$];

  `include "keccak_ref.svh"

  keccak_miner_core dut0 (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (start),
    .header (header),
    .nonce  (nonce),
    .target (target),
    .busy   (busy),
    .done   (done),
    .match  (match),
    .digest (digest)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_with_failure(string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [255:0] expected, logic [255:0] actual);
    if (expected !== actual)
      stop_with_failure($sformatf("ERROR %s expected 0x%0h actual 0x%0h",
                                  name, expected, actual));
  endtask

  function automatic header_t random_header();
    header_t r;
    for (int i = 0; i < header_w / 32; i++)
    begin
      r[i*32 +: 32] = $urandom();
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus helpers for the falling edge
  ////////////////////////////////////////////////////////////
  task automatic launch_run(string name, header_t hv, nonce_t nv, target_t tv);
    header = hv;
    nonce  = nv;
    target = tv;
    start  = 1'b1;
    name_q.push_back(name);
    header_q.push_back(hv);
    nonce_q.push_back(nv);
    target_q.push_back(tv);
    // start is taken at the next rising edge
    start_edge_q.push_back(cycle + 1);
    @(negedge clk);
    start = 1'b0;
    check_value($sformatf("%s busy", name), 256'(1), 256'(busy));
  endtask

  task automatic wait_for_done();
    while (done !== 1'b1)
      @(negedge clk);
  endtask

  task automatic run_hash(string name, header_t hv, nonce_t nv, target_t tv);
    launch_run(name, hv, nv, tv);
    wait_for_done();
    @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // comparison against the reference model
  ////////////////////////////////////////////////////////////
  always @(negedge clk)
  begin
    if (arst_n && done)
    begin
      if (name_q.size() == 0)
        stop_with_failure("done pulsed while no run was in flight");
      else
      begin
        exp_digest = expected_digest(header_q[0], nonce_q[0]);
        check_value($sformatf("%s digest", name_q[0]), exp_digest, digest);
        check_value($sformatf("%s match", name_q[0]),
                    256'(expected_match(exp_digest, target_q[0])), 256'(match));
        check_value($sformatf("%s latency", name_q[0]),
                    256'(latency), 256'(cycle - start_edge_q[0]));
        void'(name_q.pop_front());
        void'(header_q.pop_front());
        void'(nonce_q.pop_front());
        void'(target_q.pop_front());
        void'(start_edge_q.pop_front());
      end
    end
  end

  // cycle count that also bounds the run
  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (cycle >= timeout_cycles)
      stop_with_failure("timeout, the test did not finish within the cycle limit");
  end

  initial
  begin
    void'($urandom(seed));
    arst_n = 1'b0;
    start  = 1'b0;
    header = '0;
    nonce  = '0;
    target = '0;
    repeat (10) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    // outputs idle after reset
    check_value("reset done", 256'(0), 256'(done));
    check_value("reset busy", 256'(0), 256'(busy));
    check_value("reset match", 256'(0), 256'(match));
    check_value("reset digest", 256'(0), digest);

    // reference model against the empty-input keccak-256 digest
    check_value("reference empty input",
                256'hc5d2460186f7233c927e7db2dcc703c0e500b653ca82273b7bfad8045d85a470,
                squeeze_digest(keccak_f1600(absorb_block({8'h80, {134{8'h00}}, 8'h01}))));

    run_hash("known answer", '0, '0, '1);

    for (int i = 0; i < n_random; i++)
    begin
      h = random_header();
      n = $urandom();
      run_hash($sformatf("random %0d", i), h, n, {$urandom(), $urandom()});
    end

    ////////////////////////////////////////////////////////////
    // target compare at the boundary
    ////////////////////////////////////////////////////////////
    h = random_header();
    n = $urandom();
    d = expected_digest(h, n);
    run_hash("target equal", h, n, d[63:0]);
    check_value("target equal flag", 256'(1), 256'(match));
    run_hash("target below", h, n, d[63:0] - 64'd1);
    check_value("target below flag", 256'(0), 256'(match));
    run_hash("target ones", h, n, '1);
    check_value("target ones flag", 256'(1), 256'(match));

    // a start while busy is dropped and a start at done is taken
    h = random_header();
    n = $urandom();
    launch_run("busy start", h, n, '1);
    repeat (5) @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    wait_for_done();
    h = random_header();
    n = $urandom();
    launch_run("back to back", h, n, '1);
    wait_for_done();
    repeat (latency + 5) @(negedge clk);

    if (name_q.size() != 0)
      stop_with_failure("a started run never produced done");
    else
    begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+bench
rtl/keccak_pkg.sv
rtl/miner_pkg.sv
rtl/keccak_pad.sv
rtl/keccak_round.sv
rtl/keccak_permutation.sv
rtl/hash_target_check.sv
rtl/keccak_miner_core.sv
bench/tb_keccak_miner.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_keccak_miner
FLAGS     ?= --binary --assert -j 0
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f filelist.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)
